//--- menu_pkg.sv
/*
  Shared types and constants for the menu background painter.
  Coordinates are plain 11-bit counters, active area 800 x 600.
  Letter rectangles use exclusive bounds and are matched in table order.
  Only the "GAME" title and the "PLAY" label are kept in the table.
*/

package menu_pkg;

  localparam int COUNT_W = 11;
  localparam int RGB_W   = 12;

  localparam int HOR_PIXELS = 800;
  localparam int VER_PIXELS = 600;
  localparam int FRAME_GAP  = 5;   // Inner frame line offset from the edge

  // 4 bits each of red, green, blue
  localparam logic [RGB_W-1:0] BLACK  = 12'h000;
  localparam logic [RGB_W-1:0] BLUE   = 12'h00f;
  localparam logic [RGB_W-1:0] YELLOW = 12'hff0;

  typedef struct packed {
    logic [COUNT_W-1:0] vcount;
    logic               vsync;
    logic               vblnk;
    logic [COUNT_W-1:0] hcount;
    logic               hsync;
    logic               hblnk;
  } vga_timing_t;

  typedef struct packed {
    vga_timing_t        timing;
    logic [RGB_W-1:0]   rgb;
  } vga_pixel_t;

  // Pixel is inside when vmin < vcount < vmax and hmin < hcount < hmax
  typedef struct packed {
    logic [COUNT_W-1:0] vmin;
    logic [COUNT_W-1:0] vmax;
    logic [COUNT_W-1:0] hmin;
    logic [COUNT_W-1:0] hmax;
    logic [RGB_W-1:0]   colour;
  } menu_rect_t;

  localparam int N_RECTS = 33;

  // vmin, vmax, hmin, hmax, colour
  localparam menu_rect_t MENU_RECTS [N_RECTS] = '{
    // Title "GAME", letter G
    '{170, 215, 574, 584, BLUE},
    '{170, 180, 574, 604, BLUE},
    '{205, 215, 574, 599, BLUE},
    '{190, 200, 589, 604, BLUE},
    '{190, 215, 596, 604, BLUE},
    // A
    '{175, 215, 609, 619, BLUE},
    '{175, 215, 624, 634, BLUE},
    '{170, 180, 614, 629, BLUE},
    '{190, 200, 609, 634, BLUE},
    // M, two legs then the diagonal steps
    '{170, 215, 639, 649, BLUE},
    '{170, 215, 669, 679, BLUE},
    '{180, 190, 648, 658, BLUE},
    '{180, 190, 660, 670, BLUE},
    '{189, 199, 654, 664, BLUE},
    // E
    '{170, 215, 684, 694, BLUE},
    '{170, 180, 684, 709, BLUE},
    '{205, 215, 684, 709, BLUE},
    '{188, 198, 684, 704, BLUE},
    // Label "PLAY", letter P
    '{334, 434, 437, 447, YELLOW},
    '{334, 344, 437, 467, YELLOW},
    '{343, 385, 466, 477, YELLOW},
    '{384, 394, 437, 467, YELLOW},
    // L
    '{334, 434, 482, 492, YELLOW},
    '{424, 434, 482, 517, YELLOW},
    // A
    '{343, 434, 522, 532, YELLOW},
    '{343, 434, 552, 562, YELLOW},
    '{334, 345, 531, 553, YELLOW},
    '{373, 383, 522, 562, YELLOW},
    // Y, stem first then the arms
    '{374, 434, 580, 590, YELLOW},
    '{364, 384, 572, 582, YELLOW},
    '{364, 384, 587, 597, YELLOW},
    '{334, 374, 567, 577, YELLOW},
    '{334, 374, 592, 602, YELLOW}
  };

endpackage

//--- vga_frame_border.sv
/*
  Double frame around the visible area, purely combinational.
  Outer line sits on the screen edge, inner line FRAME_GAP pixels in.
  The inner line stops short of the corners, its ends are excluded.
  Blanking is not looked at here, the output stage handles it.
*/

module vga_frame_border (
  input  menu_pkg::vga_timing_t vga_in,
  output logic                  on_frame
);

  import menu_pkg::*;

  logic outer_line;
  logic inner_hline;  // Top and bottom inner segments
  logic inner_vline;  // Left and right inner segments
  logic h_inside;
  logic v_inside;

  // Strictly between the inner line positions
  assign h_inside = (vga_in.hcount > FRAME_GAP) &&
                    (vga_in.hcount < HOR_PIXELS - FRAME_GAP);
  assign v_inside = (vga_in.vcount > FRAME_GAP) &&
                    (vga_in.vcount < VER_PIXELS - FRAME_GAP);

  assign outer_line = (vga_in.vcount == 0) ||
                      (vga_in.hcount == 0) ||
                      (vga_in.vcount == VER_PIXELS - 1) ||
                      (vga_in.hcount == HOR_PIXELS - 1);

  assign inner_hline = ((vga_in.vcount == FRAME_GAP) ||
                        (vga_in.vcount == VER_PIXELS - FRAME_GAP)) && h_inside;

  assign inner_vline = ((vga_in.hcount == FRAME_GAP) ||
                        (vga_in.hcount == HOR_PIXELS - FRAME_GAP)) && v_inside;

  assign on_frame = outer_line || inner_hline || inner_vline;

endmodule

//--- menu_text_layer.sv
/*
  Letter layer for the menu, combinational.
  Every table rectangle is tested at once with exclusive bounds.
  The lowest table index that hits decides the colour.
  No hit gives text_hit low and a black colour.
*/

module menu_text_layer (
  input  menu_pkg::vga_timing_t       vga_in,
  output logic                        text_hit,
  output logic [menu_pkg::RGB_W-1:0]  text_rgb
);

  import menu_pkg::*;

  logic [N_RECTS-1:0] rect_hit;

  // One comparator set per rectangle
  for (genvar i = 0; i < N_RECTS; i++) begin : g_rect
    logic v_in;
    logic h_in;

    assign v_in = (vga_in.vcount > MENU_RECTS[i].vmin) &&
                  (vga_in.vcount < MENU_RECTS[i].vmax);
    assign h_in = (vga_in.hcount > MENU_RECTS[i].hmin) &&
                  (vga_in.hcount < MENU_RECTS[i].hmax);

    assign rect_hit[i] = v_in && h_in;
  end

  assign text_hit = |rect_hit;

  // Walk down so the lowest index is written last and wins
  always_comb begin
    text_rgb = BLACK;
    for (int i = N_RECTS - 1; i >= 0; i--) begin
      if (rect_hit[i]) begin
        text_rgb = MENU_RECTS[i].colour;
      end
    end
  end

endmodule

//--- menu_pixel_out.sv
/*
  Output stage, the only register in the painter.
  Colour priority: blanking black, then frame blue, then letter colour.
  Timing fields leave one clock after they enter, sync flags untouched.
  Synchronous reset clears the whole outgoing word.
*/

module menu_pixel_out (
  input  logic                        clk,
  input  logic                        rst,
  input  menu_pkg::vga_timing_t       vga_in,
  input  logic                        on_frame,
  input  logic                        text_hit,
  input  logic [menu_pkg::RGB_W-1:0]  text_rgb,
  output menu_pkg::vga_pixel_t        vga_out
);

  import menu_pkg::*;

  logic [RGB_W-1:0] rgb_nxt;

  always_comb begin
    if (vga_in.hblnk || vga_in.vblnk) begin
      rgb_nxt = BLACK;
    end else if (on_frame) begin
      rgb_nxt = BLUE;
    end else if (text_hit) begin
      rgb_nxt = text_rgb;
    end else begin
      rgb_nxt = BLACK;  // Background
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      vga_out <= '0;
    end else begin
      vga_out.timing <= vga_in;
      vga_out.rgb    <= rgb_nxt;
    end
  end

  // Blanked output never carries colour
  assert property (@(posedge clk) disable iff (rst)
    (vga_out.timing.hblnk || vga_out.timing.vblnk) |-> (vga_out.rgb == BLACK))
    else $error("colour on a blanked pixel");

  // Timing comes out exactly one clock late
  assert property (@(posedge clk) disable iff (rst)
    !$past(rst) |-> (vga_out.timing == $past(vga_in)))
    else $error("timing fields not delayed by one clock");

endmodule

//--- main_menu.sv
/*
  Menu background painter, top level.
  One pixel in and one pixel out per clock, latency fixed at one clock.
  No handshake, the caller must supply a valid timing word every cycle.
*/

module main_menu (
  input  logic                  clk,
  input  logic                  rst,
  input  menu_pkg::vga_timing_t vga_in,
  output menu_pkg::vga_pixel_t  vga_out
);

  import menu_pkg::*;

  logic             on_frame;
  logic             text_hit;
  logic [RGB_W-1:0] text_rgb;

  vga_frame_border u_border (
    .vga_in   (vga_in),
    .on_frame (on_frame)
  );

  menu_text_layer u_text (
    .vga_in   (vga_in),
    .text_hit (text_hit),
    .text_rgb (text_rgb)
  );

  // Register stage, merges the layers
  menu_pixel_out u_out (
    .clk      (clk),
    .rst      (rst),
    .vga_in   (vga_in),
    .on_frame (on_frame),
    .text_hit (text_hit),
    .text_rgb (text_rgb),
    .vga_out  (vga_out)
  );

endmodule

//--- menu_vectors.svh
/*
  Directed vectors for the menu painter testbench.
  Expected colours are worked out by hand from the frame and letter rules.
  Included inside the testbench module after the package import.
*/

`ifndef MENU_VECTORS_SVH
`define MENU_VECTORS_SVH

  // Columns: hcount, vcount, hblnk, vblnk, hsync, vsync, label, expected rgb
  typedef struct packed {
    logic [COUNT_W-1:0] hcount;
    logic [COUNT_W-1:0] vcount;
    logic               hblnk;
    logic               vblnk;
    logic               hsync;
    logic               vsync;
    logic [8*16-1:0]    label;
    logic [RGB_W-1:0]   rgb;
  } vector_t;

  localparam int N_VECS = 34;

  localparam vector_t VECTORS [N_VECS] = '{
    // Outer line, corners and edges
    '{  0,   0, 0, 0, 0, 0, "corner tl",      BLUE},
    '{799, 599, 0, 0, 0, 0, "corner br",      BLUE},
    '{799,   0, 0, 0, 0, 0, "corner tr",      BLUE},
    '{400,   0, 0, 0, 0, 0, "outer top",      BLUE},
    '{400, 599, 0, 0, 0, 0, "outer bottom",   BLUE},
    '{  0, 300, 0, 0, 0, 0, "outer left",     BLUE},
    '{799, 300, 0, 0, 0, 0, "outer right",    BLUE},
    // Inner line
    '{  5, 300, 0, 0, 0, 0, "inner left",     BLUE},
    '{795, 300, 0, 0, 0, 0, "inner right",    BLUE},
    '{400,   5, 0, 0, 0, 0, "inner top",      BLUE},
    '{400, 595, 0, 0, 0, 0, "inner bottom",   BLUE},
    '{  5,   3, 0, 0, 0, 0, "inner end",      BLACK},  // Ends excluded
    '{  5,   5, 0, 0, 0, 0, "inner corner",   BLACK},
    '{  2, 300, 0, 0, 0, 0, "between lines",  BLACK},
    '{  4, 100, 0, 0, 0, 0, "between lines",  BLACK},
    // Title letters
    '{578, 190, 0, 0, 0, 0, "G stem",         BLUE},
    '{590, 175, 0, 0, 0, 0, "G top",          BLUE},
    '{612, 200, 0, 0, 0, 0, "A leg",          BLUE},
    '{653, 185, 0, 0, 0, 0, "M step",         BLUE},
    '{700, 193, 0, 0, 0, 0, "E middle",       BLUE},
    // Label letters
    '{440, 380, 0, 0, 0, 0, "P stem",         YELLOW},
    '{500, 430, 0, 0, 0, 0, "L foot",         YELLOW},
    '{540, 378, 0, 0, 0, 0, "A bar",          YELLOW},
    '{585, 400, 0, 0, 0, 0, "Y stem",         YELLOW},
    // Exclusive bounds and gaps
    '{578, 170, 0, 0, 0, 0, "G top bound",    BLACK},
    '{574, 190, 0, 0, 0, 0, "G left bound",   BLACK},
    '{606, 190, 0, 0, 0, 0, "letter gap",     BLACK},
    // Areas of the removed title part and banner
    '{330, 175, 0, 0, 0, 0, "dropped title",  BLACK},
    '{260, 100, 0, 0, 0, 0, "dropped banner", BLACK},
    // Blanking wins over frame and letters
    '{  0,   0, 1, 0, 1, 0, "blank frame",    BLACK},
    '{578, 190, 0, 1, 0, 1, "blank letter",   BLACK},
    '{440, 380, 1, 1, 1, 1, "blank label",    BLACK},
    '{400,   0, 0, 0, 1, 1, "sync active",    BLUE},
    '{900, 650, 1, 1, 1, 0, "porch",          BLACK}   // Counters past visible area
  };

`endif

//--- tb_main_menu.sv
/*
  Testbench for the menu background painter.
  Directed vectors come from menu_vectors.svh, random points from an LFSR.
  Random points are active pixels only, with sync flags low.
  Expected colours for random points come from a reference model here.
*/

module tb_main_menu;

  timeunit 1ns;
  timeprecision 1ps;

  import menu_pkg::*;

  `include "menu_vectors.svh"

  localparam int          RESET_CYCLES = 4;
  localparam int          N_RANDOM     = 400;
  localparam int          CYCLE_LIMIT  = RESET_CYCLES + N_VECS + N_RANDOM + 20;
  localparam logic [31:0] LFSR_SEED    = 32'h6a5c_b322;
  localparam logic [31:0] LFSR_TAPS    = 32'h8020_0003;  // x^32 + x^22 + x^2 + x + 1

  logic        clk = 1'b0;
  logic        rst;
  vga_timing_t vga_in;
  vga_pixel_t  vga_out;

  logic [31:0] lfsr_state;
  int          cycle_count = 0;
  int          error_count;
  int          tests_passed;
  int          tests_failed;
  logic        test_failed;

  main_menu dut (
    .clk     (clk),
    .rst     (rst),
    .vga_in  (vga_in),
    .vga_out (vga_out)
  );

  always #50 clk = ~clk;

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count > CYCLE_LIMIT) begin
      $display("Timeout: the run went past %0d clock cycles without ending", CYCLE_LIMIT);
      $display("Finished with errors");
      $finish;
    end
  end

  function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    if (state[0]) begin
      return (state >> 1) ^ LFSR_TAPS;
    end
    return state >> 1;
  endfunction

  // One LFSR step per bit, oldest bit ends up at the top
  task automatic take_random_bits(input int n, output logic [31:0] value);
    value = '0;
    for (int i = 0; i < n; i++) begin
      value = {value[30:0], lfsr_state[0]};
      lfsr_state = lfsr_step(lfsr_state);
    end
  endtask

  function automatic logic frame_expected(input int h, input int v);
    logic outer;
    logic inner_top_bottom;
    logic inner_sides;
    outer = (h == 0) || (v == 0) || (h == HOR_PIXELS - 1) || (v == VER_PIXELS - 1);
    inner_top_bottom = (v == FRAME_GAP || v == VER_PIXELS - FRAME_GAP) &&
                       h > FRAME_GAP && h < HOR_PIXELS - FRAME_GAP;
    inner_sides = (h == FRAME_GAP || h == HOR_PIXELS - FRAME_GAP) &&
                  v > FRAME_GAP && v < VER_PIXELS - FRAME_GAP;
    return outer || inner_top_bottom || inner_sides;
  endfunction

  // Colour of an active pixel, first matching rule wins
  function automatic logic [RGB_W-1:0] expected_colour(input int h, input int v);
    if (frame_expected(h, v)) begin
      return BLUE;
    end
    foreach (MENU_RECTS[i]) begin
      if (v > MENU_RECTS[i].vmin && v < MENU_RECTS[i].vmax &&
          h > MENU_RECTS[i].hmin && h < MENU_RECTS[i].hmax) begin
        return MENU_RECTS[i].colour;
      end
    end
    return BLACK;
  endfunction

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (actual !== expected) begin
      $display("[FAIL] time %0t: %s expected %0h, got %0h", $time, name, expected, actual);
      error_count++;
      test_failed = 1'b1;
    end
  endtask

  task automatic check_pixel(input vga_timing_t exp_t, input logic [RGB_W-1:0] exp_rgb);
    check_value("vga_out.rgb", exp_rgb, vga_out.rgb);
    check_value("vga_out.hcount", exp_t.hcount, vga_out.timing.hcount);
    check_value("vga_out.vcount", exp_t.vcount, vga_out.timing.vcount);
    check_value("vga_out.hblnk", exp_t.hblnk, vga_out.timing.hblnk);
    check_value("vga_out.vblnk", exp_t.vblnk, vga_out.timing.vblnk);
    check_value("vga_out.hsync", exp_t.hsync, vga_out.timing.hsync);
    check_value("vga_out.vsync", exp_t.vsync, vga_out.timing.vsync);
  endtask

  task automatic drive_pixel(input int h, input int v, input logic hb, input logic vb,
                             input logic hs, input logic vs);
    vga_in.hcount = COUNT_W'(h);
    vga_in.vcount = COUNT_W'(v);
    vga_in.hblnk  = hb;
    vga_in.vblnk  = vb;
    vga_in.hsync  = hs;
    vga_in.vsync  = vs;
  endtask

  task automatic finish_test(input string label);
    if (test_failed) begin
      tests_failed++;
      $display("test %s: failed", label);
    end else begin
      tests_passed++;
      $display("test %s: passed", label);
    end
    test_failed = 1'b0;
  endtask

  initial begin
    vga_timing_t      expected_t;
    logic [RGB_W-1:0] expected_rgb;
    logic [31:0]      h_raw;
    logic [31:0]      v_raw;
    int               h;
    int               v;

    rst          = 1'b1;
    vga_in       = '0;
    lfsr_state   = LFSR_SEED;
    error_count  = 0;
    tests_passed = 0;
    tests_failed = 0;
    test_failed  = 1'b0;

    // A visible frame pixel with sync high, reset must still hold zero
    drive_pixel(0, 0, 0, 0, 1, 1);
    for (int i = 0; i < RESET_CYCLES; i++) begin
      @(posedge clk);
      #5;
      check_value("vga_out", '0, vga_out);
    end
    rst = 1'b0;
    check_value("vga_out", '0, vga_out);  // First cycle out of reset
    finish_test("reset");

    for (int i = 0; i < N_VECS; i++) begin
      drive_pixel(VECTORS[i].hcount, VECTORS[i].vcount, VECTORS[i].hblnk,
                  VECTORS[i].vblnk, VECTORS[i].hsync, VECTORS[i].vsync);
      expected_t = vga_in;
      @(posedge clk);
      #5;
      check_pixel(expected_t, VECTORS[i].rgb);
      finish_test(string'(VECTORS[i].label));
    end

    for (int k = 0; k < N_RANDOM; k++) begin
      take_random_bits(11, h_raw);
      take_random_bits(10, v_raw);
      h = h_raw % HOR_PIXELS;
      v = v_raw % VER_PIXELS;
      drive_pixel(h, v, 0, 0, 0, 0);
      expected_t   = vga_in;
      expected_rgb = expected_colour(h, v);
      @(posedge clk);
      #5;
      check_pixel(expected_t, expected_rgb);
    end
    finish_test($sformatf("random points x%0d", N_RANDOM));

    $display("Tests passed: %0d, tests failed: %0d, mismatches: %0d",
             tests_passed, tests_failed, error_count);
    if (tests_failed == 0 && error_count == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

//--- src.f
+incdir+.
menu_pkg.sv
vga_frame_border.sv
menu_text_layer.sv
menu_pixel_out.sv
main_menu.sv
tb_main_menu.sv

//--- Bender.yml
package:
  name: main_menu

sources:
  - menu_pkg.sv
  - vga_frame_border.sv
  - menu_text_layer.sv
  - menu_pixel_out.sv
  - main_menu.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_main_menu.sv
